// File: pci_exp_64b_app.f
common/pcie_tlp_pkg.sv
common/nic_regs_pkg.sv
rx/rx_tlp_decoder.sv
rx/huge_page_table.sv
tx/tlp_tx_builder.sv
src/pci_exp_64b_app.sv
testbench/pci_exp_64b_app_assert.sv
testbench/tb_pci_exp_64b_app.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator and run the testbench, result taken from sim.log
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_pci_exp_64b_app -f pci_exp_64b_app.f \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/Vtb_pci_exp_64b_app > sim.log 2>&1 ; cat sim.log

grep -q "SIMULATION FAILED" sim.log && { echo "Run failed, see sim.log"; exit 1; }
grep -q "SIMULATION PASSED" sim.log || { echo "No result found in sim.log"; exit 1; }
echo "Run passed"

// File: testbench/tb_pci_exp_64b_app.sv
// Testbench for the receive-to-host PCIe application path with clock,
// reset, BRAM model, random stimulus, reference model and checks
`timescale 1ns/1ps
`default_nettype none

module tb_pci_exp_64b_app
    import pcie_tlp_pkg::*;
    import nic_regs_pkg::*;
();

    localparam int BRAM_AW = 9;
    localparam int TIMEOUT = 400;                   // Cycles allowed per wait

    logic                 trn_clk;
    logic                 rst;
    qword_t               trn_rd;
    logic                 trn_rsof_n, trn_reof_n, trn_rsrc_rdy_n;
    logic [6:0]           trn_rbar_hit_n;
    qword_t               trn_td;
    logic [7:0]           trn_trem_n;
    logic                 trn_tsof_n, trn_teof_n, trn_tsrc_rdy_n, trn_tdst_rdy_n;
    logic [7:0]           cfg_bus_number;
    logic [4:0]           cfg_device_number;
    logic [2:0]           cfg_function_number;
    logic                 cfg_interrupt_n, cfg_interrupt_rdy_n;
    logic                 trigger_tlp, trigger_tlp_ack;
    logic [QW_CNT_W-1:0]  qwords_to_send;
    logic                 change_huge_page, change_huge_page_ack;
    logic [BRAM_AW-1:0]   commited_rd_address;
    logic [BRAM_AW-1:0]   rd_addr;
    qword_t               rd_data = '0;

    // --------------------
    // Reference model
    // --------------------
    qword_t                bram [1 << BRAM_AW];
    page_addr_t            mdl_addr [2];
    logic                  mdl_ready [2];
    logic                  mdl_sel;
    logic [PAGE_OFF_W-1:0] mdl_off;
    logic [BRAM_AW-1:0]    mdl_ptr;

    integer seed;
    int     err_cnt;
    int     chk_cnt;
    int     err_mark;
    logic   timed_out;
    logic   bp_en;                                  // Random trn_tdst_rdy_n stalls

    pci_exp_64b_app #(
        .BRAM_AW (BRAM_AW)
    ) dut (.*);

    bind pci_exp_64b_app pci_exp_64b_app_assert u_assert (
        .trn_clk             (trn_clk),
        .rst                 (rst),
        .trn_td              (trn_td),
        .trn_tsof_n          (trn_tsof_n),
        .trn_teof_n          (trn_teof_n),
        .trn_tsrc_rdy_n      (trn_tsrc_rdy_n),
        .trn_tdst_rdy_n      (trn_tdst_rdy_n),
        .cfg_interrupt_n     (cfg_interrupt_n),
        .cfg_interrupt_rdy_n (cfg_interrupt_rdy_n)
    );

    initial begin
        trn_clk = 1'b0;
        forever #10 trn_clk = ~trn_clk;
    end

    always @(posedge trn_clk) begin
        rd_data <= bram[rd_addr];                   // One cycle read latency
    end

    task automatic check_eq(input logic [63:0] actual, input logic [63:0] expected,
                            input string msg);
        chk_cnt++;
        if (actual !== expected) begin
            err_cnt++;
            $display("Fail at %0t ns: %s, got %h, expected %h", $time, msg, actual, expected);
        end
    endtask

    task automatic note_timeout(input string what);
        timed_out = 1'b1;
        err_cnt++;
        $display("Timeout: %s did not happen within %0d cycles", what, TIMEOUT);
    endtask

    task automatic report_test(input int num, input string name);
        $display("Test %0d %s: %0d errors", num, name, err_cnt - err_mark);
        err_mark = err_cnt;
    endtask

    function automatic int rand_n();
        return ($random(seed) & 15) + 1;
    endfunction

    function automatic page_addr_t rand_page();
        return {$random(seed), $random(seed) & 32'hffe00000};  // 2 MiB aligned
    endfunction

    // Two beat TLP on the RX link with the model updated only for a valid BAR0 MWr32
    task automatic write_reg(input logic [REG_OFF_W-1:0] off, input logic [31:0] data,
                             input logic [1:0] fmt, input logic [6:0] hit);
        logic [31:0] r;
        r = $random(seed);
        @(negedge trn_clk);
        trn_rd         = {1'b0, fmt, TLP_TYPE_MEM, 14'h0000, 10'd1, r[31:8], 8'h0f};
        trn_rsof_n     = 1'b0;
        trn_reof_n     = 1'b1;
        trn_rsrc_rdy_n = 1'b0;
        trn_rbar_hit_n = hit;
        @(negedge trn_clk);
        trn_rd     = {r[23:0], off, data};
        trn_rsof_n = 1'b1;
        trn_reof_n = 1'b0;
        @(negedge trn_clk);
        trn_rsrc_rdy_n = 1'b1;
        trn_reof_n     = 1'b1;
        @(negedge trn_clk);                         // Table updated by now
        if (fmt == TLP_FMT_MWR32 && !hit[0]) begin
            case (off)
                REG_SLOT0_LO:  if (!mdl_ready[0]) mdl_addr[0][31:0] = data;
                REG_SLOT0_HI:  if (!mdl_ready[0]) mdl_addr[0][63:32] = data;
                REG_SLOT0_ARM: mdl_ready[0] = 1'b1;
                REG_SLOT1_LO:  if (!mdl_ready[1]) mdl_addr[1][31:0] = data;
                REG_SLOT1_HI:  if (!mdl_ready[1]) mdl_addr[1][63:32] = data;
                REG_SLOT1_ARM: mdl_ready[1] = 1'b1;
                default: ;
            endcase
        end
    endtask

    task automatic set_slot(input int s, input page_addr_t a);
        write_reg(s == 0 ? REG_SLOT0_LO : REG_SLOT1_LO, a[31:0], TLP_FMT_MWR32, 7'h7e);
        write_reg(s == 0 ? REG_SLOT0_HI : REG_SLOT1_HI, a[63:32], TLP_FMT_MWR32, 7'h7e);
        write_reg(s == 0 ? REG_SLOT0_ARM : REG_SLOT1_ARM, 32'h1, TLP_FMT_MWR32, 7'h7e);
    endtask

    // --------------------
    // TX TLP capture
    // --------------------
    task automatic send_tlp(input int n);
        qword_t      beats [$];
        logic [31:0] r;
        int          cnt;
        int          i;
        logic        done;
        if (timed_out) return;
        done = 1'b0;
        cnt  = 0;
        @(negedge trn_clk);
        trigger_tlp    = 1'b1;
        qwords_to_send = (n == 16) ? '0 : QW_CNT_W'(n);
        while (!done && cnt < TIMEOUT) begin
            r = $random(seed);
            trn_tdst_rdy_n = bp_en && r[0];
            if (!trn_tsrc_rdy_n && !trn_tdst_rdy_n) begin   // Taken at next posedge
                beats.push_back(trn_td);
                check_eq(64'(trn_tsof_n), 64'(beats.size() != 1), "trn_tsof_n on beat");
                check_eq(64'(trn_teof_n), 64'(beats.size() != n + 2), "trn_teof_n on beat");
            end
            @(negedge trn_clk);
            cnt++;
            done = trigger_tlp_ack;
        end
        trigger_tlp    = 1'b0;
        trn_tdst_rdy_n = 1'b0;
        if (!done) begin
            note_timeout("trigger_tlp_ack");
            return;
        end
        check_eq(64'(beats.size()), 64'(n + 2), "beat count");
        if (beats.size() == n + 2) begin
            check_eq(64'(beats[0][62:61]), 64'(TLP_FMT_MWR64), "dword 0 format");
            check_eq(64'(beats[0][60:56]), 64'(TLP_TYPE_MEM), "dword 0 type");
            check_eq(64'(beats[0][41:32]), 64'(2 * n), "dword 0 length");
            check_eq(64'(beats[0][31:0]), 64'({cfg_bus_number, cfg_device_number,
                     cfg_function_number, 8'h00, BE_ALL}), "dword 1");
            check_eq(beats[1], mdl_addr[mdl_sel] + 64'(mdl_off), "target address");
            for (i = 0; i < n; i++) begin
                check_eq(beats[i + 2], bram[mdl_ptr + BRAM_AW'(i)], "data beat");
            end
        end
        check_eq(64'(trn_trem_n), 64'(0), "trn_trem_n");
        mdl_ptr = mdl_ptr + BRAM_AW'(n);
        mdl_off = mdl_off + PAGE_OFF_W'(8 * n);
        check_eq(64'(commited_rd_address), 64'(mdl_ptr), "commited_rd_address");
    endtask

    task automatic change_page();
        logic [31:0] r;
        int          cnt;
        int          dly;
        if (timed_out) return;
        @(negedge trn_clk);
        change_huge_page = 1'b1;
        cnt = 0;
        while (cfg_interrupt_n && cnt < TIMEOUT) begin
            @(negedge trn_clk);
            cnt++;
        end
        if (cfg_interrupt_n) begin
            change_huge_page = 1'b0;
            note_timeout("cfg_interrupt_n assertion");
            return;
        end
        r   = $random(seed);
        dly = 32'(r[2:0]);
        repeat (dly) begin                          // Host slow to take the interrupt
            @(negedge trn_clk);
            check_eq(64'(cfg_interrupt_n), 64'(0), "cfg_interrupt_n held low");
        end
        cfg_interrupt_rdy_n = 1'b0;
        cnt = 0;
        while (!change_huge_page_ack && cnt < TIMEOUT) begin
            @(negedge trn_clk);
            cnt++;
        end
        cfg_interrupt_rdy_n = 1'b1;
        change_huge_page    = 1'b0;
        if (!change_huge_page_ack) begin
            note_timeout("change_huge_page_ack");
            return;
        end
        check_eq(64'(cfg_interrupt_n), 64'(1), "cfg_interrupt_n released");
        mdl_ready[mdl_sel] = 1'b0;
        mdl_sel            = !mdl_sel;
        mdl_off            = '0;
    endtask

    // --------------------
    // Test sequence
    // --------------------
    initial begin
        logic [31:0] r;
        int          i;
        seed      = 32'hf2e80d71;
        err_cnt   = 0;
        chk_cnt   = 0;
        err_mark  = 0;
        timed_out = 1'b0;
        bp_en     = 1'b0;
        rst                 = 1'b1;
        trn_rd              = '0;
        trn_rsof_n          = 1'b1;
        trn_reof_n          = 1'b1;
        trn_rsrc_rdy_n      = 1'b1;
        trn_rbar_hit_n      = 7'h7f;
        trn_tdst_rdy_n      = 1'b0;
        cfg_interrupt_rdy_n = 1'b1;
        trigger_tlp         = 1'b0;
        qwords_to_send      = '0;
        change_huge_page    = 1'b0;
        r                   = $random(seed);
        cfg_bus_number      = r[7:0];
        cfg_device_number   = r[12:8];
        cfg_function_number = r[15:13];
        for (i = 0; i < (1 << BRAM_AW); i++) begin
            bram[i] = {$random(seed), $random(seed)};
        end
        mdl_addr[0]  = '0;
        mdl_addr[1]  = '0;
        mdl_ready[0] = 1'b0;
        mdl_ready[1] = 1'b0;
        mdl_sel      = 1'b0;
        mdl_off      = '0;
        mdl_ptr      = '0;
        repeat (3) @(negedge trn_clk);
        rst = 1'b0;

        check_eq(64'({trn_tsrc_rdy_n, trn_tsof_n, trn_teof_n, cfg_interrupt_n}), 64'(4'hf),
                 "TX flags after reset");
        check_eq(64'({trigger_tlp_ack, change_huge_page_ack}), 64'(0), "acks after reset");
        check_eq(64'(commited_rd_address), 64'(0), "commited_rd_address after reset");
        set_slot(0, rand_page());
        send_tlp(rand_n());
        report_test(1, "header and slot 0 address");

        repeat (70) send_tlp(rand_n());             // Wraps the BRAM pointer
        report_test(2, "BRAM data and read pointer");

        repeat (4) send_tlp(16);
        report_test(3, "page offset growth");

        set_slot(1, rand_page());
        change_page();
        send_tlp(rand_n());
        r = $random(seed);
        write_reg(REG_SLOT1_LO, r, TLP_FMT_MWR32, 7'h7e);
        send_tlp(rand_n());
        set_slot(0, rand_page());
        change_page();
        send_tlp(rand_n());
        report_test(4, "page change and slot locking");

        r = $random(seed);
        write_reg(REG_SLOT1_LO, r, TLP_FMT_MWR64, 7'h7e);
        r = $random(seed);
        write_reg(REG_SLOT1_HI, r, TLP_FMT_MWR32, 7'h7d);   // BAR1 only
        write_reg(REG_SLOT1_ARM, 32'h1, TLP_FMT_MWR32, 7'h7e);
        change_page();
        send_tlp(rand_n());
        report_test(5, "rejected register writes");

        bp_en = 1'b1;
        repeat (20) send_tlp(rand_n());
        bp_en = 1'b0;
        report_test(6, "random back-pressure");

        $display("Tests: 6, checks: %0d, errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0 && !timed_out) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/pci_exp_64b_app_assert.sv
// Concurrent checks on TX local link beats
// and the legacy interrupt handshake
`timescale 1ns/1ps
`default_nettype none

module pci_exp_64b_app_assert
    import pcie_tlp_pkg::*;
(
    input wire logic   trn_clk,
    input wire logic   rst,
    input wire qword_t trn_td,
    input wire logic   trn_tsof_n,
    input wire logic   trn_teof_n,
    input wire logic   trn_tsrc_rdy_n,
    input wire logic   trn_tdst_rdy_n,
    input wire logic   cfg_interrupt_n,
    input wire logic   cfg_interrupt_rdy_n
);

    // Stalled beat keeps its data and framing
    a_tx_hold: assert property (@(posedge trn_clk) disable iff (rst)
        (!trn_tsrc_rdy_n && trn_tdst_rdy_n) |=>
            (!trn_tsrc_rdy_n && $stable(trn_td) && $stable(trn_tsof_n) && $stable(trn_teof_n)))
        else $error("TX beat changed while stalled");

    a_tx_frame: assert property (@(posedge trn_clk) disable iff (rst)
        (!trn_tsof_n || !trn_teof_n) |-> !trn_tsrc_rdy_n)
        else $error("TX sof or eof without source ready");

    // Interrupt held until the core takes it
    a_irq_hold: assert property (@(posedge trn_clk) disable iff (rst)
        (!cfg_interrupt_n && cfg_interrupt_rdy_n) |=> !cfg_interrupt_n)
        else $error("cfg_interrupt_n released before cfg_interrupt_rdy_n");

endmodule

`default_nettype wire

// File: src/pci_exp_64b_app.sv
// PCIe application top, receive-to-host path:
// RX register decoder, huge page table and TX TLP builder
`timescale 1ns/1ps
`default_nettype none

module pci_exp_64b_app
    import pcie_tlp_pkg::*;
    import nic_regs_pkg::*;
#(
    parameter int BRAM_AW = 9
) (
    input  wire logic                 trn_clk,
    input  wire logic                 rst,

    // RX local link
    input  wire qword_t               trn_rd,
    input  wire logic                 trn_rsof_n,
    input  wire logic                 trn_reof_n,
    input  wire logic                 trn_rsrc_rdy_n,
    input  wire logic [6:0]           trn_rbar_hit_n,

    // TX local link
    output qword_t                    trn_td,
    output logic [7:0]                trn_trem_n,
    output logic                      trn_tsof_n,
    output logic                      trn_teof_n,
    output logic                      trn_tsrc_rdy_n,
    input  wire logic                 trn_tdst_rdy_n,

    // Configuration
    input  wire logic [7:0]           cfg_bus_number,
    input  wire logic [4:0]           cfg_device_number,
    input  wire logic [2:0]           cfg_function_number,
    output logic                      cfg_interrupt_n,
    input  wire logic                 cfg_interrupt_rdy_n,

    // Packet logic
    input  wire logic                 trigger_tlp,
    output logic                      trigger_tlp_ack,
    input  wire logic [QW_CNT_W-1:0]  qwords_to_send,
    input  wire logic                 change_huge_page,
    output logic                      change_huge_page_ack,
    output logic [BRAM_AW-1:0]        commited_rd_address,

    // Receive BRAM read port
    output logic [BRAM_AW-1:0]        rd_addr,
    input  wire qword_t               rd_data
);

    logic                 reg_wr;
    logic [REG_OFF_W-1:0] reg_off;
    logic [31:0]          reg_data;
    page_addr_t           cur_addr;
    logic                 cur_valid;
    logic                 page_free;

    rx_tlp_decoder u_rx_tlp_decoder (
        .trn_clk        (trn_clk),
        .rst            (rst),
        .trn_rd         (trn_rd),
        .trn_rsof_n     (trn_rsof_n),
        .trn_reof_n     (trn_reof_n),
        .trn_rsrc_rdy_n (trn_rsrc_rdy_n),
        .trn_rbar_hit_n (trn_rbar_hit_n),
        .reg_wr         (reg_wr),
        .reg_off        (reg_off),
        .reg_data       (reg_data)
    );

    huge_page_table u_huge_page_table (
        .trn_clk   (trn_clk),
        .rst       (rst),
        .reg_wr    (reg_wr),
        .reg_off   (reg_off),
        .reg_data  (reg_data),
        .page_free (page_free),
        .cur_addr  (cur_addr),
        .cur_valid (cur_valid)
    );

    tlp_tx_builder #(
        .BRAM_AW (BRAM_AW)
    ) u_tlp_tx_builder (
        .trn_clk              (trn_clk),
        .rst                  (rst),
        .trigger_tlp          (trigger_tlp),
        .trigger_tlp_ack      (trigger_tlp_ack),
        .qwords_to_send       (qwords_to_send),
        .change_huge_page     (change_huge_page),
        .change_huge_page_ack (change_huge_page_ack),
        .commited_rd_address  (commited_rd_address),
        .cur_addr             (cur_addr),
        .cur_valid            (cur_valid),
        .page_free            (page_free),
        .rd_addr              (rd_addr),
        .rd_data              (rd_data),
        .trn_td               (trn_td),
        .trn_trem_n           (trn_trem_n),
        .trn_tsof_n           (trn_tsof_n),
        .trn_teof_n           (trn_teof_n),
        .trn_tsrc_rdy_n       (trn_tsrc_rdy_n),
        .trn_tdst_rdy_n       (trn_tdst_rdy_n),
        .cfg_bus_number       (cfg_bus_number),
        .cfg_device_number    (cfg_device_number),
        .cfg_function_number  (cfg_function_number),
        .cfg_interrupt_n      (cfg_interrupt_n),
        .cfg_interrupt_rdy_n  (cfg_interrupt_rdy_n)
    );

endmodule

`default_nettype wire

// File: tx/tlp_tx_builder.sv
// Memory-write TLP builder from the receive BRAM,
// page offset tracking, page change and legacy interrupt
`timescale 1ns/1ps
`default_nettype none

module tlp_tx_builder
    import pcie_tlp_pkg::*;
    import nic_regs_pkg::*;
#(
    parameter int BRAM_AW = 9
) (
    input  wire logic                 trn_clk,
    input  wire logic                 rst,

    // Packet logic
    input  wire logic                 trigger_tlp,
    output logic                      trigger_tlp_ack,
    input  wire logic [QW_CNT_W-1:0]  qwords_to_send,
    input  wire logic                 change_huge_page,
    output logic                      change_huge_page_ack,
    output logic [BRAM_AW-1:0]        commited_rd_address,

    // Huge page table
    input  wire page_addr_t           cur_addr,
    input  wire logic                 cur_valid,
    output logic                      page_free,

    // Receive BRAM, one cycle read latency
    output logic [BRAM_AW-1:0]        rd_addr,
    input  wire qword_t               rd_data,

    // TX local link
    output qword_t                    trn_td,
    output logic [7:0]                trn_trem_n,
    output logic                      trn_tsof_n,
    output logic                      trn_teof_n,
    output logic                      trn_tsrc_rdy_n,
    input  wire logic                 trn_tdst_rdy_n,

    // Configuration and interrupt
    input  wire logic [7:0]           cfg_bus_number,
    input  wire logic [4:0]           cfg_device_number,
    input  wire logic [2:0]           cfg_function_number,
    output logic                      cfg_interrupt_n,
    input  wire logic                 cfg_interrupt_rdy_n
);

    typedef enum logic [2:0] {S_IDLE, S_HDR, S_ADDR, S_DATA, S_IRQ} tx_state_t;

    tx_state_t               state;
    logic [QW_CNT_W-1:0]     qw_req;                // Request size, 0 decoded
    logic [QW_CNT_W-1:0]     qw_n;                  // Size of the TLP in flight
    logic [QW_CNT_W-1:0]     reads_left;            // BRAM reads still to issue
    logic [QW_CNT_W-1:0]     data_left;             // Data beats not yet on the bus
    logic [PAGE_OFF_W-1:0]   page_off;
    logic [TLP_LEN_W-1:0]    tlp_len;
    qword_t                  hdr_beat;
    qword_t                  hold_q;
    logic                    hold_vld;
    logic                    rd_pend;               // rd_data valid this cycle
    logic                    beat_done;
    logic                    bus_free;
    logic                    src_vld;
    logic                    load_data;
    logic                    issue;

    assign qw_req  = (qwords_to_send == '0) ? QW_CNT_W'(16) : qwords_to_send;
    assign tlp_len = TLP_LEN_W'({qw_req, 1'b0});    // Two dwords per qword

    // MWr64, TC 0, no digest, completer ID as requester, tag 0
    assign hdr_beat = {1'b0, TLP_FMT_MWR64, TLP_TYPE_MEM, 14'h0000, tlp_len,
                       cfg_bus_number, cfg_device_number, cfg_function_number,
                       8'h00, BE_ALL};

    assign trn_trem_n = 8'h00;                      // Always full qwords

    assign beat_done = !trn_tsrc_rdy_n && !trn_tdst_rdy_n;
    assign bus_free  = trn_tsrc_rdy_n || !trn_tdst_rdy_n;
    assign src_vld   = hold_vld || rd_pend;
    assign load_data = (state == S_ADDR || state == S_DATA) && bus_free &&
                       (data_left != '0) && src_vld;

    // Keep at most one qword staged outside the bus register
    assign issue = (reads_left != '0) && !(src_vld && !load_data);

    // --------------------
    // BRAM prefetch
    // --------------------
    always_ff @(posedge trn_clk) begin
        if (rst) begin
            rd_pend  <= 1'b0;
            hold_vld <= 1'b0;
            rd_addr  <= '0;
        end else begin
            rd_pend  <= issue;
            hold_vld <= src_vld && !load_data;
            if (issue) begin
                rd_addr <= rd_addr + BRAM_AW'(1);
            end
        end
        if (rd_pend && !load_data) begin            // Park data under back-pressure
            hold_q <= rd_data;
        end
    end

    // --------------------
    // TLP and interrupt FSM
    // --------------------
    always_ff @(posedge trn_clk) begin
        trigger_tlp_ack      <= 1'b0;
        change_huge_page_ack <= 1'b0;
        page_free            <= 1'b0;
        if (rst) begin
            state               <= S_IDLE;
            trn_tsof_n          <= 1'b1;
            trn_teof_n          <= 1'b1;
            trn_tsrc_rdy_n      <= 1'b1;
            cfg_interrupt_n     <= 1'b1;
            reads_left          <= '0;
            data_left           <= '0;
            page_off            <= '0;
            commited_rd_address <= '0;
        end else begin
            if (issue) begin
                reads_left <= reads_left - QW_CNT_W'(1);
            end
            if (load_data) begin
                trn_td    <= hold_vld ? hold_q : rd_data;
                data_left <= data_left - QW_CNT_W'(1);
            end
            case (state)
                S_IDLE: begin
                    // Requests seen during their ack cycle are stale
                    if (change_huge_page && !change_huge_page_ack) begin
                        cfg_interrupt_n <= 1'b0;
                        page_free       <= 1'b1;    // Table flips on the next edge
                        state           <= S_IRQ;
                    end else if (trigger_tlp && !trigger_tlp_ack && cur_valid) begin
                        trn_td         <= hdr_beat;
                        trn_tsof_n     <= 1'b0;
                        trn_tsrc_rdy_n <= 1'b0;
                        qw_n           <= qw_req;
                        reads_left     <= qw_req;
                        data_left      <= qw_req;
                        state          <= S_HDR;
                    end
                end
                S_HDR: begin
                    if (beat_done) begin
                        trn_td     <= cur_addr + page_addr_t'(page_off);
                        trn_tsof_n <= 1'b1;
                        state      <= S_ADDR;
                    end
                end
                S_ADDR, S_DATA: begin
                    if (load_data) begin
                        trn_tsrc_rdy_n <= 1'b0;
                        trn_teof_n     <= (data_left != QW_CNT_W'(1));
                        state          <= S_DATA;
                    end else if (bus_free && data_left != '0) begin
                        trn_tsrc_rdy_n <= 1'b1;     // Wait for BRAM data
                        trn_teof_n     <= 1'b1;
                        state          <= S_DATA;
                    end else if (beat_done) begin   // Last beat taken
                        trn_tsrc_rdy_n      <= 1'b1;
                        trn_teof_n          <= 1'b1;
                        trigger_tlp_ack     <= 1'b1;
                        commited_rd_address <= commited_rd_address + BRAM_AW'(qw_n);
                        page_off            <= page_off + PAGE_OFF_W'({qw_n, 3'b000});
                        state               <= S_IDLE;
                    end
                end
                S_IRQ: begin
                    if (!cfg_interrupt_rdy_n) begin
                        cfg_interrupt_n      <= 1'b1;
                        change_huge_page_ack <= 1'b1;
                        page_off             <= '0; // Next page starts at its base
                        state                <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rx/huge_page_table.sv
// Two-slot huge page table with host arming,
// ping-pong selection and release by the TX builder
`timescale 1ns/1ps
`default_nettype none

module huge_page_table
    import nic_regs_pkg::*;
(
    input  wire logic                 trn_clk,
    input  wire logic                 rst,

    // Register writes from the decoder
    input  wire logic                 reg_wr,
    input  wire logic [REG_OFF_W-1:0] reg_off,
    input  wire logic [31:0]          reg_data,

    // TX builder side
    input  wire logic                 page_free,
    output page_addr_t                cur_addr,
    output logic                      cur_valid
);

    localparam logic [REG_OFF_W-1:0] LO_OFF  [2] = '{REG_SLOT0_LO, REG_SLOT1_LO};
    localparam logic [REG_OFF_W-1:0] HI_OFF  [2] = '{REG_SLOT0_HI, REG_SLOT1_HI};
    localparam logic [REG_OFF_W-1:0] ARM_OFF [2] = '{REG_SLOT0_ARM, REG_SLOT1_ARM};

    page_slot_t slot [2];
    logic       sel;                                // Slot currently being filled

    always_ff @(posedge trn_clk) begin
        if (rst) begin
            slot[0].ready <= 1'b0;
            slot[1].ready <= 1'b0;
            sel           <= 1'b0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                // Address is locked while the NIC owns the page
                if (reg_wr && !slot[i].ready) begin
                    if (reg_off == LO_OFF[i]) begin
                        slot[i].addr[31:0] <= reg_data;
                    end
                    if (reg_off == HI_OFF[i]) begin
                        slot[i].addr[63:32] <= reg_data;
                    end
                end
                if (reg_wr && reg_off == ARM_OFF[i]) begin
                    slot[i].ready <= 1'b1;
                end
            end
            if (page_free) begin                    // Hand page back, move on
                slot[sel].ready <= 1'b0;
                sel             <= !sel;
            end
        end
    end

    assign cur_addr  = slot[sel].addr;
    assign cur_valid = slot[sel].ready;

endmodule

`default_nettype wire

// File: rx/rx_tlp_decoder.sv
// Receive TLP decoder, single dword BAR0 memory writes
// turned into register write pulses
`timescale 1ns/1ps
`default_nettype none

module rx_tlp_decoder
    import pcie_tlp_pkg::*;
    import nic_regs_pkg::*;
(
    input  wire logic                 trn_clk,
    input  wire logic                 rst,

    // RX local link, always accepted
    input  wire qword_t               trn_rd,
    input  wire logic                 trn_rsof_n,
    input  wire logic                 trn_reof_n,
    input  wire logic                 trn_rsrc_rdy_n,
    input  wire logic [6:0]           trn_rbar_hit_n,

    // Register write port
    output logic                      reg_wr,
    output logic [REG_OFF_W-1:0]      reg_off,
    output logic [31:0]               reg_data
);

    typedef enum logic {RX_SOF, RX_BEAT1} rx_state_t;

    rx_state_t rx_state;
    logic      beat_vld;
    logic      hdr_ok;

    assign beat_vld = !trn_rsrc_rdy_n;

    // Dword 0 sits in the upper half of beat 0
    assign hdr_ok = (trn_rd[62:61] == TLP_FMT_MWR32) &&
                    (trn_rd[60:56] == TLP_TYPE_MEM) &&
                    (trn_rd[32 +: TLP_LEN_W] == TLP_LEN_W'(1)) &&
                    trn_reof_n &&                   // Single beat frames rejected
                    !trn_rbar_hit_n[0];             // BAR0 only

    always_ff @(posedge trn_clk) begin
        reg_wr <= 1'b0;
        if (rst) begin
            rx_state <= RX_SOF;
        end else if (beat_vld) begin
            if (!trn_rsof_n) begin                  // Any sof restarts the parse
                rx_state <= hdr_ok ? RX_BEAT1 : RX_SOF;
            end else if (rx_state == RX_BEAT1) begin
                rx_state <= RX_SOF;
                if (!trn_reof_n) begin              // Exactly two beats long
                    reg_wr   <= 1'b1;
                    reg_off  <= trn_rd[32 +: REG_OFF_W];
                    reg_data <= trn_rd[31:0];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: common/nic_regs_pkg.sv
// BAR0 register map, huge page slot type
// and page geometry
`default_nettype none

package nic_regs_pkg;

    localparam int REG_OFF_W = 8;                   // Decoded BAR0 address bits

    // --------------------
    // BAR0 offsets
    // --------------------
    localparam logic [REG_OFF_W-1:0] REG_SLOT0_LO  = 8'h00;
    localparam logic [REG_OFF_W-1:0] REG_SLOT0_HI  = 8'h04;
    localparam logic [REG_OFF_W-1:0] REG_SLOT0_ARM = 8'h08;
    localparam logic [REG_OFF_W-1:0] REG_SLOT1_LO  = 8'h10;
    localparam logic [REG_OFF_W-1:0] REG_SLOT1_HI  = 8'h14;
    localparam logic [REG_OFF_W-1:0] REG_SLOT1_ARM = 8'h18;

    // --------------------
    // Huge pages
    // --------------------
    localparam int PAGE_OFF_W = 21;                 // 2 MiB page
    localparam int QW_CNT_W   = 5;                  // Qwords per TLP, 0 means 16

    typedef logic [63:0] page_addr_t;               // Host bus address

    typedef struct packed {
        page_addr_t addr;
        logic       ready;                          // Armed by host, owned by NIC
    } page_slot_t;

endpackage

`default_nettype wire

// File: common/pcie_tlp_pkg.sv
// TLP header field codes, field widths
// and the 64-bit TRN data beat type
`default_nettype none

package pcie_tlp_pkg;

    typedef logic [63:0] qword_t;                   // One TRN local link beat

    // --------------------
    // Header dword 0
    // --------------------
    localparam logic [1:0] TLP_FMT_MWR32 = 2'b10;   // 3DW header with data
    localparam logic [1:0] TLP_FMT_MWR64 = 2'b11;   // 4DW header with data
    localparam logic [4:0] TLP_TYPE_MEM  = 5'b00000;
    localparam int         TLP_LEN_W     = 10;      // Length field, in dwords

    // --------------------
    // Header dword 1
    // --------------------
    // Last and first dword byte enables, every byte valid
    localparam logic [7:0] BE_ALL = 8'hff;

endpackage

`default_nettype wire
